//--- verilog/icache_pkg.sv
/*
 * Instruction cache core-side types.
 * Byte address, instruction word and the payload
 * of a fetch request from the core.
 */

`default_nettype none

package icache_pkg;

    // --------------------
    // Basic widths.
    // --------------------

    // Byte address on the fetch port.
    typedef logic [31:0] addr_t;

    // Instruction or memory word.
    typedef logic [31:0] word_t;

    // --------------------
    // Fetch request.
    // --------------------

    // Payload that travels with i_fetch_valid.
    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

endpackage

`default_nettype wire

//--- verilog/axil_pkg.sv
/*
 * AXI4-Lite read channel definitions.
 * AR and R payload structs and the response codes.
 */

`default_nettype none

package axil_pkg;

    // Response codes.
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_EXOKAY = 2'b01;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    // --------------------
    // Read channels.
    // --------------------

    // Read address channel payload.
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } ar_t;

    // Read data channel payload.
    typedef struct packed {
        logic [31:0] data;
        resp_t       resp;
    } r_t;

endpackage

`default_nettype wire

//--- verilog/icache_lookup.sv
/*
 * Instruction cache decode stage.
 * Registers the fetch address, splits it into tag, index
 * and word offset, and checks the tag and valid arrays.
 * Also commits the tag of a freshly filled line.
 */

`default_nettype none

module icache_lookup #(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                          clk,
    input  logic                          arst,

    input  logic                          i_start,
    input  icache_pkg::fetch_req_t        i_req,
    input  logic                          i_tag_we,
    input  logic                          i_flush,

    output logic                          o_hit,
    output logic [$clog2(NUM_LINES)-1:0]  o_index,
    output logic [$clog2(LINE_WORDS)-1:0] o_offset,
    output icache_pkg::addr_t             o_line_base
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [IDX_W-1:0] index_t;

    icache_pkg::fetch_req_t req_q;
    tag_t                   req_tag;
    index_t                 req_index;

    tag_t                   tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0]   valid_q;

    // --------------------
    // Request capture.
    // --------------------

    always_ff @(posedge clk) begin
        if (i_start) begin
            req_q <= i_req;
        end
    end

    // Address split.
    assign req_tag   = req_q.addr[31 -: TAG_W];
    assign req_index = req_q.addr[OFF_W + 2 +: IDX_W];

    assign o_index     = req_index;
    assign o_offset    = req_q.addr[2 +: OFF_W];
    assign o_line_base = {req_tag, req_index, {(OFF_W + 2){1'b0}}};

    // Tag compare.
    assign o_hit = valid_q[req_index] && (tag_mem[req_index] == req_tag);

    // --------------------
    // Tag and valid arrays.
    // --------------------

    always_ff @(posedge clk) begin
        if (i_tag_we) begin
            tag_mem[req_index] <= req_tag;
        end
    end

    // Flush wipes every line at once.
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            valid_q <= '0;
        end else if (i_flush) begin
            valid_q <= '0;
        end else if (i_tag_we) begin
            valid_q[req_index] <= 1'b1;
        end
    end

    // Flush only happens in idle, tag commit only at the end of a fill.
    a_no_flush_on_commit : assert property (
        @(posedge clk) disable iff (arst) !(i_tag_we && i_flush)
    );

endmodule

`default_nettype wire

//--- verilog/icache_ctrl.sv
/*
 * Instruction cache execute stage.
 * Three-state controller that accepts a fetch, runs the
 * tag lookup, starts a line fill on a miss and commits
 * the new tag once the last word has arrived.
 */

`default_nettype none

module icache_ctrl (
    input  logic clk,
    input  logic arst,

    input  logic i_fetch_valid,
    input  logic i_flush_req,
    input  logic i_hit,
    input  logic i_fill_last,

    output logic o_fetch_ready,
    output logic o_lookup_start,
    output logic o_flush,
    output logic o_fill_active,
    output logic o_tag_we,
    output logic o_resp_valid
);

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        LOOKUP = 2'b01,
        FILL   = 2'b10
    } state_t;

    state_t state_q;
    state_t state_d;

    // --------------------
    // State register.
    // --------------------

    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state.
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (o_lookup_start) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = i_hit ? IDLE : FILL;
            end
            FILL: begin
                // Back to lookup, which now hits on the new line.
                if (i_fill_last) begin
                    state_d = LOOKUP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // --------------------
    // Outputs.
    // --------------------

    assign o_fetch_ready  = (state_q == IDLE);
    assign o_flush        = (state_q == IDLE) && i_flush_req;
    assign o_lookup_start = (state_q == IDLE) && i_fetch_valid && !i_flush_req;
    assign o_resp_valid   = (state_q == LOOKUP) && i_hit;
    assign o_fill_active  = (state_q == FILL);
    assign o_tag_we       = (state_q == FILL) && i_fill_last;

    // The fill engine only reports a last beat for a fill we started.
    a_last_in_fill : assert property (
        @(posedge clk) disable iff (arst) i_fill_last |-> (state_q == FILL)
    );

endmodule

`default_nettype wire

//--- verilog/icache_fill.sv
/*
 * Instruction cache line fill engine.
 * AXI4-Lite read master that fetches one line as a run
 * of single-word reads, one outstanding at a time, and
 * flags the final word as the last beat.
 */

`default_nettype none

module icache_fill #(
    parameter int LINE_WORDS = 4
) (
    input  logic                          clk,
    input  logic                          arst,

    input  logic                          i_active,
    input  icache_pkg::addr_t             i_line_base,

    output logic                          o_m_arvalid,
    output axil_pkg::ar_t                 o_m_ar,
    input  logic                          i_m_arready,
    input  logic                          i_m_rvalid,
    input  axil_pkg::r_t                  i_m_r,
    output logic                          o_m_rready,

    output logic                          o_we,
    output icache_pkg::word_t             o_word,
    output logic [$clog2(LINE_WORDS)-1:0] o_offset,
    output logic                          o_last
);

    localparam int OFF_W = $clog2(LINE_WORDS);

    typedef logic [OFF_W-1:0] offset_t;

    typedef enum logic {
        ADDR = 1'b0,
        DATA = 1'b1
    } state_t;

    state_t  state_q;
    offset_t cnt_q;
    logic    arvalid_q;
    logic    active_q;
    logic    beat;
    logic    last_beat;

    assign beat      = (state_q == DATA) && i_m_rvalid;
    assign last_beat = beat && (cnt_q == offset_t'(LINE_WORDS - 1));

    // --------------------
    // Word sequencer.
    // --------------------

    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            state_q   <= ADDR;
            cnt_q     <= '0;
            arvalid_q <= 1'b0;
            active_q  <= 1'b0;
        end else begin
            active_q <= i_active;
            case (state_q)
                ADDR: begin
                    if (i_active && !active_q) begin
                        arvalid_q <= 1'b1;
                    end else if (arvalid_q && i_m_arready) begin
                        arvalid_q <= 1'b0;
                        state_q   <= DATA;
                    end
                end
                DATA: begin
                    if (beat) begin
                        state_q <= ADDR;
                        // Next word goes out right after this one lands.
                        if (!last_beat) begin
                            cnt_q     <= cnt_q + 1'b1;
                            arvalid_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= ADDR;
            endcase
            if (!i_active) begin
                cnt_q <= '0;
            end
        end
    end

    // --------------------
    // AXI and fill outputs.
    // --------------------

    assign o_m_arvalid = arvalid_q;
    assign o_m_ar      = '{addr: i_line_base + icache_pkg::addr_t'({cnt_q, 2'b00}),
                           prot: 3'b000};
    assign o_m_rready  = (state_q == DATA);

    assign o_we     = beat;
    assign o_word   = i_m_r.data;
    assign o_offset = cnt_q;
    assign o_last   = last_beat;

    a_ar_stable : assert property (
        @(posedge clk) disable iff (arst)
        (o_m_arvalid && !i_m_arready) |=> (o_m_arvalid && $stable(o_m_ar))
    );

    // No error recovery, so a bad response must never come back.
    a_resp_okay : assert property (
        @(posedge clk) disable iff (arst)
        (i_m_rvalid && o_m_rready) |-> (i_m_r.resp == axil_pkg::RESP_OKAY)
    );

endmodule

`default_nettype wire

//--- verilog/icache_data.sv
/*
 * Instruction cache result stage.
 * Word array of NUM_LINES lines by LINE_WORDS words.
 * Takes fill words during a line fill and reads out the
 * requested instruction for the response.
 */

`default_nettype none

module icache_data #(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                          clk,

    // Lookup side.
    input  logic [$clog2(NUM_LINES)-1:0]  i_index,
    input  logic [$clog2(LINE_WORDS)-1:0] i_offset,

    // Fill side.
    input  logic                          i_we,
    input  logic [$clog2(LINE_WORDS)-1:0] i_wr_offset,
    input  icache_pkg::word_t             i_wr_word,

    output icache_pkg::word_t             o_instr
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int OFF_W = $clog2(LINE_WORDS);

    typedef logic [IDX_W-1:0] index_t;
    typedef logic [OFF_W-1:0] offset_t;

    index_t            line_sel;
    offset_t           rd_sel;
    offset_t           wr_sel;

    icache_pkg::word_t mem [NUM_LINES][LINE_WORDS];

    assign line_sel = i_index;
    assign rd_sel   = i_offset;
    assign wr_sel   = i_wr_offset;

    // --------------------
    // Fill write.
    // --------------------

    // The line being filled is always the one under lookup.
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[line_sel][wr_sel] <= i_wr_word;
        end
    end

    // --------------------
    // Instruction read.
    // --------------------

    // Combinational, so a hit answers in the lookup cycle.
    assign o_instr = mem[line_sel][rd_sel];

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
/*
 * Direct-mapped instruction cache top level.
 * Joins lookup, controller, fill engine and data array
 * to the core fetch port and the AXI4-Lite read port.
 */

`default_nettype none

module icache_top #(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                   clk,
    input  logic                   arst,

    // Fetch port.
    input  logic                   i_fetch_valid,
    input  icache_pkg::fetch_req_t i_fetch_req,
    output logic                   o_fetch_ready,
    output logic                   o_fetch_rvalid,
    output icache_pkg::word_t      o_fetch_instr,

    input  logic                   i_flush,

    // AXI4-Lite read master.
    output logic                   o_m_arvalid,
    output axil_pkg::ar_t          o_m_ar,
    input  logic                   i_m_arready,
    input  logic                   i_m_rvalid,
    input  axil_pkg::r_t           i_m_r,
    output logic                   o_m_rready
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int OFF_W = $clog2(LINE_WORDS);

    // --------------------
    // Internal wires.
    // --------------------

    logic              lookup_start;
    logic              flush;
    logic              hit;
    logic [IDX_W-1:0]  line_index;
    logic [OFF_W-1:0]  word_offset;
    icache_pkg::addr_t line_base;

    logic              fill_active;
    logic              fill_we;
    icache_pkg::word_t fill_word;
    logic [OFF_W-1:0]  fill_offset;
    logic              fill_last;
    logic              tag_we;

    icache_lookup #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) u_lookup (
        .clk         (clk),
        .arst        (arst),
        .i_start     (lookup_start),
        .i_req       (i_fetch_req),
        .i_tag_we    (tag_we),
        .i_flush     (flush),
        .o_hit       (hit),
        .o_index     (line_index),
        .o_offset    (word_offset),
        .o_line_base (line_base)
    );

    icache_ctrl u_ctrl (
        .clk            (clk),
        .arst           (arst),
        .i_fetch_valid  (i_fetch_valid),
        .i_flush_req    (i_flush),
        .i_hit          (hit),
        .i_fill_last    (fill_last),
        .o_fetch_ready  (o_fetch_ready),
        .o_lookup_start (lookup_start),
        .o_flush        (flush),
        .o_fill_active  (fill_active),
        .o_tag_we       (tag_we),
        .o_resp_valid   (o_fetch_rvalid)
    );

    icache_fill #(
        .LINE_WORDS (LINE_WORDS)
    ) u_fill (
        .clk         (clk),
        .arst        (arst),
        .i_active    (fill_active),
        .i_line_base (line_base),
        .o_m_arvalid (o_m_arvalid),
        .o_m_ar      (o_m_ar),
        .i_m_arready (i_m_arready),
        .i_m_rvalid  (i_m_rvalid),
        .i_m_r       (i_m_r),
        .o_m_rready  (o_m_rready),
        .o_we        (fill_we),
        .o_word      (fill_word),
        .o_offset    (fill_offset),
        .o_last      (fill_last)
    );

    icache_data #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) u_data (
        .clk         (clk),
        .i_index     (line_index),
        .i_offset    (word_offset),
        .i_we        (fill_we),
        .i_wr_offset (fill_offset),
        .i_wr_word   (fill_word),
        .o_instr     (o_fetch_instr)
    );

endmodule

`default_nettype wire

//--- verif/axil_mem_model.sv
/*
 * AXI4-Lite read slave for the cache testbench.
 * Answers one read at a time with data equal to the address
 * XOR A5A5_0000, after a random arready and rvalid delay.
 */

`default_nettype none

module axil_mem_model (
    input  logic          clk,
    input  logic          arst,
    input  logic          i_arvalid,
    input  axil_pkg::ar_t i_ar,
    output logic          o_arready,
    output logic          o_rvalid,
    output axil_pkg::r_t  o_r,
    input  logic          i_rready
);

    integer      seed;
    int          ar_wait;
    int          r_wait;
    logic        busy;
    logic        rst_s;
    logic        arvalid_s;
    logic        ar_fire;
    logic        r_fire;
    logic [31:0] ar_addr_s;
    logic [31:0] rd_addr;

    initial begin
        seed      = 29520;
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_r       = '0;
        busy      = 1'b0;
        ar_wait   = 0;
        r_wait    = 0;
        rd_addr   = '0;
        forever begin
            @(posedge clk);
            // Handshakes as seen on this edge.
            rst_s     = arst;
            arvalid_s = i_arvalid;
            ar_addr_s = i_ar.addr;
            ar_fire   = i_arvalid && o_arready;
            r_fire    = o_rvalid && i_rready;
            #1;
            if (rst_s) begin
                o_arready = 1'b0;
                o_rvalid  = 1'b0;
                busy      = 1'b0;
            end else begin
                if (r_fire) begin
                    o_rvalid = 1'b0;
                    busy     = 1'b0;
                end
                if (ar_fire) begin
                    o_arready = 1'b0;
                    busy      = 1'b1;
                    rd_addr   = ar_addr_s;
                    r_wait    = 1 + int'($unsigned($random(seed)) % 3);
                    ar_wait   = int'($unsigned($random(seed)) % 3);
                end else if (arvalid_s && !busy && !o_arready) begin
                    if (ar_wait == 0) begin
                        o_arready = 1'b1;
                    end else begin
                        ar_wait--;
                    end
                end else if (busy && !o_rvalid) begin
                    // Data shows up once the read latency has run out.
                    if (r_wait <= 1) begin
                        o_rvalid   = 1'b1;
                        o_r.data   = rd_addr ^ 32'hA5A5_0000;
                        o_r.resp   = axil_pkg::RESP_OKAY;
                    end else begin
                        r_wait--;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/icache_tb.sv
/*
 * Instruction cache testbench.
 * Runs fetches and flushes through the cache, keeps a reference
 * of the line tags and checks responses and AXI reads.
 */

`default_nettype none

module icache_tb;

    localparam int NUM_LINES  = 16;
    localparam int LINE_WORDS = 4;
    localparam int LINE_BYTES = LINE_WORDS * 4;
    localparam int OFF_BITS   = $clog2(LINE_WORDS) + 2;
    localparam int IDX_W      = $clog2(NUM_LINES);
    // About 100 fetches, each at worst a full miss of 8 cycles per word.
    localparam int MAX_CYCLES = 100 * (LINE_WORDS * 8 + 6) + 500;

    localparam logic [31:0] BASE_A = 32'h0001_0000;
    localparam logic [31:0] BASE_B = 32'h0002_0000;
    localparam logic [31:0] BASE_C = 32'h0004_0000;

    logic                   clk = 1'b0;
    logic                   arst;
    logic                   fetch_valid;
    icache_pkg::fetch_req_t fetch_req;
    logic                   fetch_ready;
    logic                   fetch_rvalid;
    icache_pkg::word_t      fetch_instr;
    logic                   flush;
    logic                   m_arvalid;
    axil_pkg::ar_t          m_ar;
    logic                   m_arready;
    logic                   m_rvalid;
    axil_pkg::r_t           m_r;
    logic                   m_rready;

    // Reference of the cache contents and the request in flight.
    logic [NUM_LINES-1:0]   ref_valid;
    logic [31:0]            ref_tag [NUM_LINES];
    logic                   pending;
    logic                   exp_hit;
    logic [31:0]            exp_addr;
    logic [31:0]            exp_word;
    logic [31:0]            exp_base;
    int                     ar_cnt;
    int                     since_accept;
    int                     cycle_cnt = 0;
    integer                 seed;
    logic [31:0]            rnd;

    logic                   accept;
    logic                   ar_fire;
    logic [IDX_W-1:0]       req_line;
    logic [31:0]            req_tag;

    icache_top #(
        .NUM_LINES  (NUM_LINES),
        .LINE_WORDS (LINE_WORDS)
    ) uut (
        .clk            (clk),
        .arst           (arst),
        .i_fetch_valid  (fetch_valid),
        .i_fetch_req    (fetch_req),
        .o_fetch_ready  (fetch_ready),
        .o_fetch_rvalid (fetch_rvalid),
        .o_fetch_instr  (fetch_instr),
        .i_flush        (flush),
        .o_m_arvalid    (m_arvalid),
        .o_m_ar         (m_ar),
        .i_m_arready    (m_arready),
        .i_m_rvalid     (m_rvalid),
        .i_m_r          (m_r),
        .o_m_rready     (m_rready)
    );

    axil_mem_model u_mem (
        .clk       (clk),
        .arst      (arst),
        .i_arvalid (m_arvalid),
        .i_ar      (m_ar),
        .o_arready (m_arready),
        .o_rvalid  (m_rvalid),
        .o_r       (m_r),
        .i_rready  (m_rready)
    );

    always #5 clk = ~clk;

    assign accept   = fetch_valid && fetch_ready && !flush;
    assign ar_fire  = m_arvalid && m_arready;
    assign req_line = fetch_req.addr[OFF_BITS +: IDX_W];
    assign req_tag  = fetch_req.addr >> (OFF_BITS + IDX_W);
    assign exp_word = exp_addr ^ 32'hA5A5_0000;
    assign exp_base = exp_addr & ~32'(LINE_BYTES - 1);

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first failed check");
    endtask

    // --------------------
    // Reference tracking.
    // --------------------

    always @(posedge clk) begin
        if (arst) begin
            ref_valid    <= '0;
            pending      <= 1'b0;
            exp_hit      <= 1'b0;
            ar_cnt       <= 0;
            since_accept <= 0;
        end else begin
            since_accept <= since_accept + 1;
            if (ar_fire) begin
                ar_cnt <= ar_cnt + 1;
            end
            if (fetch_rvalid) begin
                pending <= 1'b0;
            end
            if (flush && fetch_ready) begin
                ref_valid <= '0;
            end else if (accept) begin
                exp_addr           <= fetch_req.addr;
                exp_hit            <= ref_valid[req_line] && (ref_tag[req_line] == req_tag);
                ref_valid[req_line] <= 1'b1;
                ref_tag[req_line]   <= req_tag;
                pending            <= 1'b1;
                ar_cnt             <= 0;
                since_accept       <= 1;
            end
        end
    end

    // --------------------
    // Checks.
    // --------------------

    a_reset_quiet : assert property (@(posedge clk)
        arst |-> (!fetch_rvalid && !m_arvalid && !m_rready))
        else report_failure("output active during reset");
    a_reset_release : assert property (@(posedge clk)
        $fell(arst) |-> (fetch_ready && !fetch_rvalid && !m_arvalid && !m_rready))
        else report_failure("wrong outputs right after reset");
    a_resp_owed : assert property (@(posedge clk) disable iff (arst)
        fetch_rvalid |-> pending)
        else report_failure("response without an accepted request");
    a_accept_clear : assert property (@(posedge clk) disable iff (arst)
        accept |-> !pending)
        else report_failure("request accepted before the previous response");
    a_resp_data : assert property (@(posedge clk) disable iff (arst)
        fetch_rvalid |-> (fetch_instr == exp_word))
        else report_failure("returned instruction differs from memory");
    a_hit_latency : assert property (@(posedge clk) disable iff (arst)
        (fetch_rvalid && exp_hit) |-> (since_accept == 1))
        else report_failure("hit not answered in the cycle after acceptance");
    a_hit_no_ar : assert property (@(posedge clk) disable iff (arst)
        ar_fire |-> (pending && !exp_hit))
        else report_failure("memory read issued for a hit or with no request");
    a_ar_order : assert property (@(posedge clk) disable iff (arst)
        ar_fire |-> ((ar_cnt < LINE_WORDS) && (m_ar.prot == 3'b000)
                     && (m_ar.addr == exp_base + 32'(ar_cnt * 4))))
        else report_failure("line fill read has a wrong address or prot");
    a_miss_reads : assert property (@(posedge clk) disable iff (arst)
        (fetch_rvalid && !exp_hit) |-> (ar_cnt == LINE_WORDS))
        else report_failure("miss answered without a full line of reads");
    a_flush_idle : assert property (@(posedge clk) disable iff (arst)
        flush |-> fetch_ready)
        else report_failure("fetch_ready low during the flush cycle");
    a_flush_silent : assert property (@(posedge clk) disable iff (arst)
        flush |=> !fetch_rvalid)
        else report_failure("response produced for a flush");

    // Watchdog.
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("The run did not finish within %0d cycles.", MAX_CYCLES);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // Stimulus.
    // --------------------

    // One fetch, with valid kept high until its response comes back.
    task automatic fetch_word(input logic [31:0] addr);
        fetch_valid    = 1'b1;
        fetch_req.addr = addr;
        while (!fetch_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        while (!fetch_rvalid) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
    endtask

    // A fetch raised together with the flush must be ignored.
    task automatic flush_lines();
        while (!fetch_ready) begin
            @(posedge clk);
            #1;
        end
        flush       = 1'b1;
        fetch_valid = 1'b1;
        @(posedge clk);
        #1;
        flush       = 1'b0;
        fetch_valid = 1'b0;
    endtask

    initial begin
        arst        = 1'b1;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        flush       = 1'b0;
        seed        = 29520;
        repeat (4) @(posedge clk);
        #1;
        arst = 1'b0;

        // Cold misses, one per line.
        for (int i = 0; i < NUM_LINES; i++) begin
            fetch_word(BASE_A + 32'(i * LINE_BYTES + (i % LINE_WORDS) * 4));
        end
        // Same lines again, other words, all hits.
        for (int i = 0; i < NUM_LINES; i++) begin
            fetch_word(BASE_A + 32'(i * LINE_BYTES + ((i + 1) % LINE_WORDS) * 4));
        end
        // Evict, refill, then hit.
        for (int idx = 3; idx < NUM_LINES; idx += 6) begin
            fetch_word(BASE_B + 32'(idx * LINE_BYTES));
            fetch_word(BASE_A + 32'(idx * LINE_BYTES));
            fetch_word(BASE_A + 32'(idx * LINE_BYTES + 4));
        end

        flush_lines();
        for (int i = 0; i < NUM_LINES / 2; i++) begin
            fetch_word(BASE_A + 32'(i * LINE_BYTES));
        end
        for (int i = 0; i < NUM_LINES / 2; i++) begin
            fetch_word(BASE_A + 32'(i * LINE_BYTES + 8));
        end

        // Random words spread over eight tags.
        for (int n = 0; n < 40; n++) begin
            rnd = $random(seed);
            fetch_word(BASE_C | {21'd0, rnd[10:8], rnd[7:2], 2'b00});
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
verilog/icache_pkg.sv
verilog/axil_pkg.sv
verilog/icache_lookup.sv
verilog/icache_ctrl.sv
verilog/icache_fill.sv
verilog/icache_data.sv
verilog/icache_top.sv
verif/axil_mem_model.sv
verif/icache_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' files.f)

.PHONY: run clean

run: obj_dir/Vicache_tb
	@out=$$(./obj_dir/Vicache_tb); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

obj_dir/Vicache_tb: files.f $(SRCS)
	verilator --binary --timing --assert --top-module icache_tb -f files.f

clean:
	rm -rf obj_dir
